/* logic/hist_pkg.sv */
// --------------------------------------------------
// shared widths, register map and bus structs
// bin address is {color, pixel}, color on top
// NUM_BINS must equal 2**BIN_AW
// register fields are 16 bit, width/height as n-1
// --------------------------------------------------
package hist_pkg;

    localparam int PIX_W    = 8;    // sensor pixel
    localparam int COLOR_W  = 2;    // bayer color
    localparam int BIN_AW   = COLOR_W + PIX_W;
    localparam int NUM_BINS = 1 << BIN_AW;
    localparam int COORD_W  = 16;   // line/pixel coordinates
    localparam int WB_AW    = 11;   // word address
    localparam int WB_DW    = 32;

    // bins sit at word addresses 0..NUM_BINS-1, registers above them
    localparam logic [WB_AW-1:0] REG_LEFT_TOP     = 11'd1024; // top high, left low
    localparam logic [WB_AW-1:0] REG_WIDTH_HEIGHT = 11'd1025; // height_m1 high, width_m1 low
    localparam logic [WB_AW-1:0] REG_CTRL         = 11'd1026; // enable, mono, bayer inv
    localparam logic [WB_AW-1:0] REG_STATUS       = 11'd1027; // state code, read only

    typedef enum logic [2:0] {
        S_CLEAR, // zero sweep after reset
        S_IDLE,
        S_ARMED, // waiting for sof
        S_FRAME,
        S_DONE   // bins readable
    } hist_state_e;

    typedef struct packed {
        logic             sof;   // one cycle before first line
        logic             eof;   // one cycle after last line
        logic             hact;
        logic [PIX_W-1:0] pixel;
    } video_in_t;

    typedef struct packed {
        logic [COORD_W-1:0] left;
        logic [COORD_W-1:0] top;
        logic [COORD_W-1:0] width_m1;
        logic [COORD_W-1:0] height_m1;
    } woi_cfg_t;

    typedef struct packed {
        logic              valid;
        logic [BIN_AW-1:0] bin;
    } bin_hit_t;

    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [WB_AW-1:0] adr;
        logic [WB_DW-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic             ack;
        logic [WB_DW-1:0] dat;
    } wb_rsp_t;

endpackage

/* logic/hist_ctrl_fsm.sv */
// --------------------------------------------------
// frame state machine and post-reset zero sweep
// S_CLEAR lasts NUM_BINS cycles after reset
// frame_end is followed by 3 drain cycles so the
// last increment lands before S_DONE
// --------------------------------------------------
`timescale 1ns/1ps

module hist_ctrl_fsm (
    input  logic                        pclk,
    input  logic                        hist_rst_pclk,
    input  logic                        enable_i,
    input  logic                        sof_i,
    input  logic                        frame_end_i,
    output hist_pkg::hist_state_e       state_o,
    output logic                        frame_start_o,
    output logic                        window_open_o,
    output logic                        clr_we_o,
    output logic [hist_pkg::BIN_AW-1:0] clr_addr_o
);

    hist_pkg::hist_state_e       state_q;
    logic [1:0]                  drain_q;    // cycles left until bins are final
    logic [hist_pkg::BIN_AW-1:0] clr_addr_q;

    assign state_o       = state_q;
    assign frame_start_o = (state_q == hist_pkg::S_ARMED) && enable_i && sof_i;
    assign window_open_o = (state_q == hist_pkg::S_FRAME) && (drain_q == 2'd0); // closed while draining
    assign clr_we_o      = (state_q == hist_pkg::S_CLEAR);
    assign clr_addr_o    = clr_addr_q;

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            state_q    <= hist_pkg::S_CLEAR;
            drain_q    <= 2'd0;
            clr_addr_q <= '0;
        end else begin
            case (state_q)
                hist_pkg::S_CLEAR: begin
                    clr_addr_q <= clr_addr_q + 1'b1;
                    if (clr_addr_q == hist_pkg::BIN_AW'(hist_pkg::NUM_BINS - 1)) begin
                        state_q <= hist_pkg::S_IDLE; // last bin zeroed
                    end
                end
                hist_pkg::S_IDLE: begin
                    if (enable_i) state_q <= hist_pkg::S_ARMED;
                end
                hist_pkg::S_ARMED: begin
                    if (!enable_i)  state_q <= hist_pkg::S_IDLE;
                    else if (sof_i) state_q <= hist_pkg::S_FRAME;
                end
                hist_pkg::S_FRAME: begin
                    if (drain_q != 2'd0) begin
                        drain_q <= drain_q - 2'd1;
                        if (drain_q == 2'd1) state_q <= hist_pkg::S_DONE;
                    end else if (frame_end_i) begin
                        drain_q <= 2'd3; // pipeline depth of the accumulator
                    end
                end
                hist_pkg::S_DONE: begin
                    if (!enable_i) state_q <= hist_pkg::S_IDLE;
                end
                default: state_q <= hist_pkg::S_IDLE;
            endcase
        end
    end

endmodule

/* logic/hist_woi_counter.sv */
// --------------------------------------------------
// line/pixel counters, window test, bayer color
// lines count from frame_start, pixels from hact rise
// window bounds are inclusive, left..left+width_m1
// hit follows the windowed pixel by one cycle
// --------------------------------------------------
`timescale 1ns/1ps

module hist_woi_counter (
    input  logic                         pclk,
    input  logic                         hist_rst_pclk,
    input  logic                         frame_start_i,
    input  logic                         window_open_i,
    input  logic                         monochrome_i,
    input  logic [hist_pkg::COLOR_W-1:0] bayer_inv_i,
    input  hist_pkg::woi_cfg_t           cfg_i,
    input  hist_pkg::video_in_t          video_i,
    output hist_pkg::bin_hit_t           hit_o,
    output logic                         frame_end_o
);

    logic                         hact_d;
    logic [hist_pkg::COORD_W-1:0] line_cnt; // index of current line in frame
    logic [hist_pkg::COORD_W-1:0] pix_cnt;  // index of current pixel in line
    logic [hist_pkg::COORD_W:0]   x_last;   // one extra bit, no wrap
    logic [hist_pkg::COORD_W:0]   y_last;
    logic                         line_end;
    logic                         in_win;
    logic [hist_pkg::COLOR_W-1:0] color;

    assign x_last   = {1'b0, cfg_i.left} + {1'b0, cfg_i.width_m1};
    assign y_last   = {1'b0, cfg_i.top} + {1'b0, cfg_i.height_m1};
    assign line_end = hact_d && !video_i.hact;

    assign in_win = window_open_i && video_i.hact
                 && (pix_cnt >= cfg_i.left) && ({1'b0, pix_cnt} <= x_last)
                 && (line_cnt >= cfg_i.top) && ({1'b0, line_cnt} <= y_last);

    // line parity on top, pixel parity below
    assign color = monochrome_i ? '0 : ({line_cnt[0], pix_cnt[0]} ^ bayer_inv_i);

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            hact_d      <= 1'b0;
            line_cnt    <= '0;
            pix_cnt     <= '0;
            hit_o.valid <= 1'b0;
            frame_end_o <= 1'b0;
        end else begin
            hact_d  <= video_i.hact;
            pix_cnt <= video_i.hact ? pix_cnt + 1'b1 : '0; // restarts every line

            if (frame_start_i) line_cnt <= '0;
            else if (line_end) line_cnt <= line_cnt + 1'b1;

            hit_o.valid <= in_win;
            // last window line or a short frame cut by eof
            frame_end_o <= window_open_i
                        && (video_i.eof || (line_end && ({1'b0, line_cnt} == y_last)));
        end
        hit_o.bin <= {color, video_i.pixel};
    end

endmodule

/* logic/hist_bin_accum.sv */
// --------------------------------------------------
// read-increment-write pipeline on ram port A
// read at cycle 0, data at 1, write at 2, no stall
// same-bin hits in flight take the forwarded count
// ram port A must be read-first
// --------------------------------------------------
`timescale 1ns/1ps

module hist_bin_accum #(
    parameter int COUNT_W = 18
) (
    input  logic                        pclk,
    input  logic                        hist_rst_pclk,
    input  hist_pkg::bin_hit_t          hit_i,
    input  logic [COUNT_W-1:0]          rd_data_i,
    output logic [hist_pkg::BIN_AW-1:0] rd_addr_o,
    output logic [hist_pkg::BIN_AW-1:0] wr_addr_o,
    output logic                        wr_en_o,
    output logic [COUNT_W-1:0]          wr_data_o
);

    logic                        v1, v2, v3;   // stage valids
    logic [hist_pkg::BIN_AW-1:0] a1, a2, a3;   // stage bins
    logic [COUNT_W-1:0]          d2;           // value being written
    logic [COUNT_W-1:0]          d3;           // value written last cycle
    logic [COUNT_W-1:0]          base;
    logic [COUNT_W-1:0]          next;

    assign rd_addr_o = hit_i.bin;

    // newest matching value wins, ram data may be stale
    always_comb begin
        if (v2 && (a2 == a1))      base = d2; // write still pending
        else if (v3 && (a3 == a1)) base = d3; // written on the same edge as our read
        else                       base = rd_data_i;
    end

    assign next = (&base) ? base : base + 1'b1; // stick at all ones

    assign wr_en_o   = v2;
    assign wr_addr_o = a2;
    assign wr_data_o = d2;

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
            v3 <= 1'b0;
        end else begin
            v1 <= hit_i.valid;
            v2 <= v1;
            v3 <= v2;
        end
        a1 <= hit_i.bin;
        a2 <= a1;
        a3 <= a2;
        d2 <= next;
        d3 <= d2;
    end

endmodule

/* logic/hist_ram.sv */
// --------------------------------------------------
// bin memory, registered reads on both ports
// port B read zeroes the bin, old value returned
// ports must not write the same cycle
// --------------------------------------------------
`timescale 1ns/1ps

module hist_ram #(
    parameter int COUNT_W = 18
) (
    input  logic                        pclk,
    input  logic [hist_pkg::BIN_AW-1:0] a_rd_addr_i,
    input  logic [hist_pkg::BIN_AW-1:0] a_wr_addr_i,
    input  logic                        a_we_i,
    input  logic [COUNT_W-1:0]          a_wr_data_i,
    output logic [COUNT_W-1:0]          a_rd_data_o,
    input  logic                        b_re_i,
    input  logic [hist_pkg::BIN_AW-1:0] b_addr_i,
    output logic [COUNT_W-1:0]          b_rd_data_o
);

    logic [COUNT_W-1:0] mem [hist_pkg::NUM_BINS];

    always_ff @(posedge pclk) begin
        if (a_we_i) mem[a_wr_addr_i] <= a_wr_data_i;
        a_rd_data_o <= mem[a_rd_addr_i]; // read-first
        if (b_re_i) begin
            b_rd_data_o    <= mem[b_addr_i];
            mem[b_addr_i] <= '0; // erase on read
        end
    end

endmodule

/* logic/hist_wb_regs.sv */
// --------------------------------------------------
// wishbone classic slave, registers and bin readout
// register access acks 1 cycle later, bins 2 cycles
// bins read only in S_DONE/S_IDLE, else 0 and kept
// writes to bins are acked and dropped
// --------------------------------------------------
`timescale 1ns/1ps

module hist_wb_regs #(
    parameter int COUNT_W = 18
) (
    input  logic                         pclk,
    input  logic                         hist_rst_pclk,
    input  hist_pkg::wb_req_t            wb_i,
    output hist_pkg::wb_rsp_t            wb_o,
    input  hist_pkg::hist_state_e        state_i,
    input  logic [COUNT_W-1:0]           b_rd_data_i,
    output logic                         b_re_o,
    output logic [hist_pkg::BIN_AW-1:0]  b_addr_o,
    output hist_pkg::woi_cfg_t           cfg_o,
    output logic                         enable_o,
    output logic                         monochrome_o,
    output logic [hist_pkg::COLOR_W-1:0] bayer_inv_o
);

    logic                       ack_q;
    logic [hist_pkg::WB_DW-1:0] dat_q;
    logic                       bin_pend_q; // bin read waiting on ram
    logic                       bin_ok_q;
    logic                       start;
    logic                       bin_rd;
    logic                       bin_ok;
    logic [hist_pkg::WB_DW-1:0] reg_rdata;

    // new request only once the previous ack is gone
    assign start  = wb_i.cyc && wb_i.stb && !ack_q && !bin_pend_q;
    assign bin_rd = start && !wb_i.we && (wb_i.adr < hist_pkg::NUM_BINS);
    assign bin_ok = (state_i == hist_pkg::S_DONE) || (state_i == hist_pkg::S_IDLE);

    assign b_re_o   = bin_rd && bin_ok;
    assign b_addr_o = wb_i.adr[hist_pkg::BIN_AW-1:0];
    assign wb_o     = '{ack: ack_q, dat: dat_q};

    always_comb begin
        case (wb_i.adr)
            hist_pkg::REG_LEFT_TOP:     reg_rdata = {cfg_o.top, cfg_o.left};
            hist_pkg::REG_WIDTH_HEIGHT: reg_rdata = {cfg_o.height_m1, cfg_o.width_m1};
            hist_pkg::REG_CTRL: begin
                reg_rdata = hist_pkg::WB_DW'({bayer_inv_o, monochrome_o, enable_o});
            end
            hist_pkg::REG_STATUS:       reg_rdata = hist_pkg::WB_DW'(state_i);
            default:                    reg_rdata = '0; // unmapped reads as 0
        endcase
    end

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            ack_q        <= 1'b0;
            bin_pend_q   <= 1'b0;
            cfg_o        <= '0;
            enable_o     <= 1'b0;
            monochrome_o <= 1'b0;
            bayer_inv_o  <= '0;
        end else begin
            ack_q      <= (start && !bin_rd) || bin_pend_q; // one cycle pulse
            bin_pend_q <= bin_rd;
            if (start && wb_i.we) begin
                case (wb_i.adr)
                    hist_pkg::REG_LEFT_TOP:     {cfg_o.top, cfg_o.left} <= wb_i.dat;
                    hist_pkg::REG_WIDTH_HEIGHT: {cfg_o.height_m1, cfg_o.width_m1} <= wb_i.dat;
                    hist_pkg::REG_CTRL: begin
                        {bayer_inv_o, monochrome_o, enable_o} <= wb_i.dat[3:0];
                    end
                    default: ; // status and bins read only
                endcase
            end
        end
    end

    always_ff @(posedge pclk) begin
        bin_ok_q <= bin_ok;
        if (bin_pend_q) begin
            dat_q <= bin_ok_q ? hist_pkg::WB_DW'(b_rd_data_i) : '0; // zero extend count
        end else if (start) begin
            dat_q <= wb_i.we ? '0 : reg_rdata;
        end
    end

endmodule

/* logic/hist_top.sv */
// --------------------------------------------------
// per-color histogram of a window in a video frame
// single clock, bins read and cleared over wishbone
// counts saturate at 2**COUNT_W-1, COUNT_W 1..32
// --------------------------------------------------
`timescale 1ns/1ps

module hist_top #(
    parameter int COUNT_W = 18
) (
    input  logic                pclk,
    input  logic                hist_rst_pclk,
    input  hist_pkg::video_in_t video_i,
    input  hist_pkg::wb_req_t   wb_i,
    output hist_pkg::wb_rsp_t   wb_o
);

    hist_pkg::hist_state_e             state;
    hist_pkg::woi_cfg_t                cfg;
    hist_pkg::bin_hit_t                hit;
    logic                              enable;
    logic                              monochrome;
    logic [hist_pkg::COLOR_W-1:0]      bayer_inv;
    logic                              frame_start;
    logic                              frame_end;
    logic                              window_open;
    logic                              clr_we;
    logic [hist_pkg::BIN_AW-1:0]       clr_addr;
    logic [hist_pkg::BIN_AW-1:0]       acc_rd_addr;
    logic [hist_pkg::BIN_AW-1:0]       acc_wr_addr;
    logic                              acc_we;
    logic [COUNT_W-1:0]                acc_wr_data;
    logic                              ram_we;
    logic [hist_pkg::BIN_AW-1:0]       ram_wr_addr;
    logic [COUNT_W-1:0]                ram_wr_data;
    logic [COUNT_W-1:0]                ram_rd_data;
    logic                              b_re;
    logic [hist_pkg::BIN_AW-1:0]       b_addr;
    logic [COUNT_W-1:0]                b_rd_data;

    // clear sweep owns port A in S_CLEAR, no hits exist then
    assign ram_we      = (state == hist_pkg::S_CLEAR) ? clr_we   : acc_we;
    assign ram_wr_addr = (state == hist_pkg::S_CLEAR) ? clr_addr : acc_wr_addr;
    assign ram_wr_data = (state == hist_pkg::S_CLEAR) ? '0       : acc_wr_data;

    hist_ctrl_fsm u_ctrl (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .enable_i      (enable),
        .sof_i         (video_i.sof),
        .frame_end_i   (frame_end),
        .state_o       (state),
        .frame_start_o (frame_start),
        .window_open_o (window_open),
        .clr_we_o      (clr_we),
        .clr_addr_o    (clr_addr)
    );

    hist_woi_counter u_woi (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .frame_start_i (frame_start),
        .window_open_i (window_open),
        .monochrome_i  (monochrome),
        .bayer_inv_i   (bayer_inv),
        .cfg_i         (cfg),
        .video_i       (video_i),
        .hit_o         (hit),
        .frame_end_o   (frame_end)
    );

    hist_bin_accum #(.COUNT_W(COUNT_W)) u_accum (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .hit_i         (hit),
        .rd_data_i     (ram_rd_data),
        .rd_addr_o     (acc_rd_addr),
        .wr_addr_o     (acc_wr_addr),
        .wr_en_o       (acc_we),
        .wr_data_o     (acc_wr_data)
    );

    hist_ram #(.COUNT_W(COUNT_W)) u_ram (
        .pclk          (pclk),
        .a_rd_addr_i   (acc_rd_addr),
        .a_wr_addr_i   (ram_wr_addr),
        .a_we_i        (ram_we),
        .a_wr_data_i   (ram_wr_data),
        .a_rd_data_o   (ram_rd_data),
        .b_re_i        (b_re),
        .b_addr_i      (b_addr),
        .b_rd_data_o   (b_rd_data)
    );

    hist_wb_regs #(.COUNT_W(COUNT_W)) u_regs (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .wb_i          (wb_i),
        .wb_o          (wb_o),
        .state_i       (state),
        .b_rd_data_i   (b_rd_data),
        .b_re_o        (b_re),
        .b_addr_o      (b_addr),
        .cfg_o         (cfg),
        .enable_o      (enable),
        .monochrome_o  (monochrome),
        .bayer_inv_o   (bayer_inv)
    );

endmodule

/* testbench/hist_tb.sv */
// --------------------------------------------------
// table-driven frames through hist_top with COUNT_W = 8
// every bin is checked against a software model
// each row leaves all bins read, so all are zero again
// fixed LFSR seed and one step per bit taken
// --------------------------------------------------
`timescale 1ns/1ps

module hist_tb;

    localparam int CNT_W     = 8;
    localparam int CNT_MAX   = (1 << CNT_W) - 1; // saturation value 255
    localparam int GAP       = 4;                // blank cycles after each line
    localparam int ACK_LIMIT = 16;
    localparam int POLLS     = 2000;
    localparam int N_ROWS    = 7;

    typedef struct packed {
        logic [15:0] lines;    // lines per frame
        logic [15:0] ppl;      // pixels per line
        logic [15:0] left;
        logic [15:0] top;
        logic [15:0] wm1;      // window width - 1
        logic [15:0] hm1;      // window height - 1
        logic [1:0]  binv;     // bayer invert
        logic        mono;
        logic        cpix;     // constant pixel instead of random
        logic [7:0]  cval;
        logic [7:0]  mask;     // masks random pixels so small masks give runs
        logic        cut;      // eof after half the lines
    } frame_row_t;

    // lines ppl left top wm1 hm1 binv mono cpix cval mask cut
    localparam frame_row_t ROWS [N_ROWS] = '{
        '{12, 24, 3, 2, 15,  7, 0, 0, 0, 8'h00, 8'hff, 0}, // offset window
        '{12, 24, 5, 3, 12,  6, 1, 0, 0, 8'h00, 8'hff, 0},
        '{10, 20, 0, 1, 19,  8, 2, 0, 0, 8'h00, 8'hff, 0}, // full width
        '{14, 18, 2, 0, 10, 13, 3, 0, 0, 8'h00, 8'hff, 0}, // ends on last line
        '{16, 30, 4, 2, 21, 11, 0, 1, 0, 8'h00, 8'h03, 0}, // mono, equal runs
        '{22, 24, 1, 1, 19, 19, 0, 1, 1, 8'ha5, 8'hff, 0}, // 400 px in one bin
        '{16, 20, 2, 2, 15, 40, 1, 0, 0, 8'h00, 8'hff, 1}  // window past eof
    };

    logic                pclk;
    logic                hist_rst_pclk;
    hist_pkg::video_in_t video;
    hist_pkg::wb_req_t   wb_req;
    hist_pkg::wb_rsp_t   wb_rsp;
    logic [31:0]         lfsr;
    int                  exp_bins [hist_pkg::NUM_BINS]; // model counts

    hist_top #(.COUNT_W(CNT_W)) UUT (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .video_i       (video),
        .wb_i          (wb_req),
        .wb_o          (wb_rsp)
    );

    initial begin
        pclk = 1'b0;
        forever #20 pclk = ~pclk;
    end

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic value_error(input string msg);
        $display("** Error @ %0t: %s", $time, msg);
        abort_run();
    endtask

    // taps 32,22,2,1
    function automatic logic [7:0] lfsr_take(input int n);
        logic [7:0] v;
        logic       fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[6:0], fb};
        end
        return v;
    endfunction

    task automatic bus_access(input logic we, input logic [10:0] adr,
                              input logic [31:0] wdat, output logic [31:0] rdat);
        int n;
        @(negedge pclk);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        n = 0;
        do begin
            @(negedge pclk);
            n++;
        end while (!wb_rsp.ack && n < ACK_LIMIT);
        assert (wb_rsp.ack) else begin
            $display("no Wishbone ack within %0d cycles at word %0d", ACK_LIMIT, adr);
            abort_run();
        end
        rdat   = wb_rsp.dat;
        wb_req = '0; // request dropped right after ack
    endtask

    task automatic write_reg(input logic [10:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        bus_access(1'b1, adr, wdat, unused);
    endtask

    task automatic check_word(input logic [10:0] adr, input logic [31:0] expv);
        logic [31:0] got;
        bus_access(1'b0, adr, '0, got);
        assert (got == expv) else
            value_error($sformatf("word %0d read %0d, expected %0d", adr, got, expv));
    endtask

    task automatic wait_state(input hist_pkg::hist_state_e s);
        logic [31:0] st;
        int          polls;
        polls = 0;
        do begin
            bus_access(1'b0, hist_pkg::REG_STATUS, '0, st);
            polls++;
        end while (st[2:0] != s && polls < POLLS);
        assert (st[2:0] == s) else begin
            $display("status stuck at %0d, never reached state %0d", st[2:0], s);
            abort_run();
        end
    endtask

    // window, parity and saturation rules
    task automatic model_pixel(input frame_row_t row, input int l, input int p,
                               input logic [7:0] pix);
        logic [1:0] color;
        int         b;
        if (p >= row.left && p <= row.left + row.wm1
            && l >= row.top && l <= row.top + row.hm1) begin
            color = row.mono ? 2'b00 : ({l[0], p[0]} ^ row.binv); // line parity on top
            b     = {color, pix};
            if (exp_bins[b] < CNT_MAX) exp_bins[b]++;
        end
    endtask

    task automatic send_frame(input frame_row_t row);
        int         nlines;
        logic [7:0] pix;
        nlines = row.cut ? row.lines / 2 : row.lines;
        @(negedge pclk);
        video.sof = 1'b1;
        @(negedge pclk);
        video.sof = 1'b0;
        repeat (2) @(negedge pclk);
        for (int l = 0; l < nlines; l++) begin
            for (int p = 0; p < row.ppl; p++) begin
                pix         = row.cpix ? row.cval : (lfsr_take(8) & row.mask);
                video.hact  = 1'b1;
                video.pixel = pix;
                model_pixel(row, l, p, pix);
                @(negedge pclk);
            end
            video.hact = 1'b0;
            repeat (GAP) @(negedge pclk);
        end
        video.eof = 1'b1; // ignored once the window line count ended the frame
        @(negedge pclk);
        video.eof = 1'b0;
    endtask

    task automatic run_row(input int r);
        frame_row_t row;
        row = ROWS[r];
        foreach (exp_bins[i]) exp_bins[i] = 0;
        wait_state(hist_pkg::S_IDLE);
        write_reg(hist_pkg::REG_LEFT_TOP, {row.top, row.left});
        write_reg(hist_pkg::REG_WIDTH_HEIGHT, {row.hm1, row.wm1});
        write_reg(hist_pkg::REG_CTRL, {28'd0, row.binv, row.mono, 1'b1});
        check_word(hist_pkg::REG_LEFT_TOP, {row.top, row.left});
        check_word(hist_pkg::REG_WIDTH_HEIGHT, {row.hm1, row.wm1});
        check_word(hist_pkg::REG_CTRL, {28'd0, row.binv, row.mono, 1'b1});
        wait_state(hist_pkg::S_ARMED);
        send_frame(row);
        wait_state(hist_pkg::S_DONE);
        for (int b = 0; b < hist_pkg::NUM_BINS; b++) check_word(11'(b), exp_bins[b]);
        // every bin that held a count reads 0 the second time
        for (int b = 0; b < hist_pkg::NUM_BINS; b++) begin
            if (exp_bins[b] != 0) check_word(11'(b), 0);
        end
        write_reg(hist_pkg::REG_CTRL, {28'd0, row.binv, row.mono, 1'b0});
    endtask

    initial begin
        int cycles;
        cycles = 5 + hist_pkg::NUM_BINS; // reset and clear sweep
        for (int r = 0; r < N_ROWS; r++) begin
            cycles += ROWS[r].lines * (ROWS[r].ppl + GAP) + 16;
            cycles += 2 * hist_pkg::NUM_BINS * 4; // readout and second reads
            cycles += 64 * 4;                     // config and polls
        end
        repeat (2 * cycles + 2000) @(posedge pclk);
        $display("watchdog expired after %0d cycles, run is stuck", 2 * cycles + 2000);
        abort_run();
    end

    initial begin
        hist_rst_pclk = 1'b1;
        wb_req        = '0;
        video         = '0;
        lfsr          = 32'hdfe0;
        repeat (5) @(negedge pclk);
        hist_rst_pclk = 1'b0;
        repeat (8) begin
            @(negedge pclk);
            assert (!wb_rsp.ack) else value_error("ack high with no request");
        end
        check_word(hist_pkg::REG_STATUS, hist_pkg::S_CLEAR); // sweep still running
        wait_state(hist_pkg::S_IDLE);
        for (int r = 0; r < N_ROWS; r++) run_row(r);
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* sens_hist.f */
logic/hist_pkg.sv
logic/hist_ctrl_fsm.sv
logic/hist_woi_counter.sv
logic/hist_bin_accum.sv
logic/hist_ram.sv
logic/hist_wb_regs.sv
logic/hist_top.sv
testbench/hist_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the histogram testbench with verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module hist_tb -f sens_hist.f -o hist_sim

./obj_dir/hist_sim 2>&1 | tee "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "=== PASS ===" "$LOG"; then
    echo "simulation ended without a verdict"
    exit 1
fi
echo "simulation passed"
